//--- build.f
+incdir+rtl
rtl/sdmacPkg.sv
rtl/laneBusIf.sv
rtl/dmaRegisters.sv
rtl/scsiSequencer.sv
rtl/byteLane.sv
rtl/busMaster.sv
rtl/sdmacTop.sv
tests/sdmacSva.sv
tests/sdmacTb.sv

//--- rtl/busMaster.sv
// Memory side of the DMA path
// Requests the bus, writes one longword per cycle from the four lane heads
// and steps the address; a flush writes the partial remainder with a mask

module busMaster (
    input  logic                sclk_i,
    input  logic                reset_i,
    input  logic                startPulse_i,
    input  sdmacPkg::longword_t startAddr_i,
    input  logic                flushReq_i,
    input  logic                busGrant_i,
    input  logic                memAck_i,
    output logic                busReq_o,
    output logic                memStrobe_o,
    output sdmacPkg::longword_t memAddr_o,
    output sdmacPkg::longword_t memData_o,
    output sdmacPkg::laneMask_t memByteEn_o,
    output logic                flushDone_o,
    output logic                idle_o,
    laneBusIf.drain             laneBus
);
    import sdmacPkg::*;

    typedef enum logic [1:0] {
        BM_IDLE,
        BM_REQ,
        BM_STROBE,
        BM_RELEASE
    } bmState_t;

    bmState_t  state;
    longword_t addr;
    longword_t data;
    laneMask_t mask;
    laneMask_t filled;
    logic      allEmpty;
    logic      canWrite;
    longword_t headWord;

    assign filled   = ~laneBus.empty;
    assign allEmpty = &laneBus.empty;

    // Full longword, or whatever is left once a flush is pending
    assign canWrite = (&filled) | (flushReq_i & (|filled));

    // Lane 0 goes to the most significant byte
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            headWord[31 - 8 * i -: 8] = filled[i] ? laneBus.popData[i] : 8'h00;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            state <= BM_IDLE;
            addr  <= '0;
        end else begin
            case (state)
                BM_IDLE: begin
                    if (canWrite)
                        state <= BM_REQ;
                end
                BM_REQ: begin
                    if (busGrant_i)
                        state <= BM_STROBE;
                end
                BM_STROBE: begin
                    if (memAck_i) begin
                        state <= BM_RELEASE;
                        addr  <= addr + 32'd4;
                    end
                end
                default: state <= BM_IDLE;  // Bus released for one cycle
            endcase
            if (startPulse_i)
                addr <= startAddr_i;
        end
    end

    // Snapshot on grant so late pushes cannot disturb a running cycle
    always_ff @(posedge sclk_i) begin
        if (state == BM_REQ && busGrant_i) begin
            data <= headWord;
            mask <= filled;
        end
    end

    assign busReq_o    = (state == BM_REQ) || (state == BM_STROBE);
    assign memStrobe_o = state == BM_STROBE;
    assign memAddr_o   = addr;
    assign memData_o   = data;
    assign memByteEn_o = mask;

    // Only the written lanes give up their byte
    assign laneBus.pop = (memStrobe_o && memAck_i) ? mask : '0;

    assign flushDone_o = flushReq_i && allEmpty && (state == BM_IDLE);
    assign idle_o      = allEmpty && (state == BM_IDLE);

endmodule

//--- rtl/byteLane.sv
// One byte lane of the DMA FIFO
// Circular buffer with its own pointers; push and pop may share a cycle

`include "sdmac_defines.svh"

module byteLane (
    input  logic            sclk_i,
    input  logic            reset_i,
    input  logic            push_i,
    input  sdmacPkg::byte_t pushData_i,
    input  logic            pop_i,
    output sdmacPkg::byte_t popData_o,
    output logic            empty_o,
    output logic            full_o
);
    import sdmacPkg::*;

    localparam int Depth = `SDMAC_LANE_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    byte_t           mem [Depth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0]   count;     // One extra bit to tell full from empty
    logic            doPush;
    logic            doPop;

    assign doPush = push_i && !full_o;
    assign doPop  = pop_i && !empty_o;

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;      // Wraps on its own
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge sclk_i) begin
        if (doPush)
            mem[wrPtr] <= pushData_i;
    end

    assign popData_o = mem[rdPtr];
    assign empty_o   = count == '0;
    assign full_o    = count == (PtrW + 1)'(Depth);

endmodule

//--- rtl/dmaRegisters.sv
// Host register block: control, start address, word count, status
// Writes are single-cycle strobes, reads are a combinational mux

`include "sdmac_defines.svh"

module dmaRegisters (
    input  logic                sclk_i,
    input  logic                reset_i,
    input  logic                regWrite_i,
    input  sdmacPkg::regIdx_t   regIdx_i,
    input  logic [31:0]         regWData_i,
    output logic [31:0]         regRData_o,
    input  logic                wordTaken_i,
    input  logic                flushDone_i,
    input  logic                idle_i,
    output logic                enable_o,
    output logic                startPulse_o,
    output sdmacPkg::longword_t startAddr_o,
    output logic [15:0]         wordCount_o,
    output logic                flushReq_o,
    output logic                intr_o
);
    import sdmacPkg::*;

    logic        intEnable;
    logic        done;
    logic        countZero;
    logic [15:0] count;

    assign countZero = count == '0;

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            enable_o     <= 1'b0;
            intEnable    <= 1'b0;
            flushReq_o   <= 1'b0;
            done         <= 1'b0;
            startPulse_o <= 1'b0;
            startAddr_o  <= '0;
            count        <= '0;
        end else begin
            startPulse_o <= 1'b0;
            if (flushDone_i)
                flushReq_o <= 1'b0;         // Sticky until the bus master empties the lanes
            if (wordTaken_i && !countZero)
                count <= count - 16'd1;
            if (enable_o && countZero && idle_i)
                done <= 1'b1;
            if (regWrite_i) begin
                case (regIdx_i)
                    `SDMAC_REG_CTRL: begin
                        enable_o  <= regWData_i[`SDMAC_CTRL_ENABLE];
                        intEnable <= regWData_i[`SDMAC_CTRL_INTEN];
                        done      <= 1'b0;
                        if (regWData_i[`SDMAC_CTRL_FLUSH])
                            flushReq_o <= 1'b1;
                        // A flush command does not restart the transfer
                        startPulse_o <= regWData_i[`SDMAC_CTRL_ENABLE] &
                                        ~regWData_i[`SDMAC_CTRL_FLUSH];
                    end
                    `SDMAC_REG_ADDR:  startAddr_o <= regWData_i;
                    `SDMAC_REG_COUNT: count <= regWData_i[15:0];
                    default: ;                  // Status is read only
                endcase
            end
        end
    end

    always_comb begin
        case (regIdx_i)
            `SDMAC_REG_CTRL:  regRData_o = {29'd0, intEnable, flushReq_o, enable_o};
            `SDMAC_REG_ADDR:  regRData_o = startAddr_o;
            `SDMAC_REG_COUNT: regRData_o = {16'd0, count};
            default:          regRData_o = {29'd0, idle_i, countZero, done};
        endcase
    end

    assign wordCount_o = count;
    assign intr_o      = done & intEnable;

endmodule

//--- rtl/laneBusIf.sv
// Push and pop bundle between the SCSI sequencer, the byte lanes
// and the bus master
// Each field carries one entry per lane

interface laneBusIf;
    import sdmacPkg::*;

    laneMask_t  push;       // Write strobe per lane
    laneBytes_t pushData;
    laneMask_t  pop;        // Read strobe per lane
    laneBytes_t popData;    // Oldest byte of each lane
    laneMask_t  empty;
    laneMask_t  full;

    // SCSI side fills the lanes
    modport feeder (
        output push,
        output pushData,
        input  full
    );

    // Memory side drains them
    modport drain (
        output pop,
        input  popData,
        input  empty
    );

    // The lane array itself
    modport lanes (
        input  push,
        input  pushData,
        input  pop,
        output popData,
        output empty,
        output full
    );

endinterface

//--- rtl/scsiSequencer.sv
// SCSI side of the DMA path
// Answers the controller's DMA request with a one-cycle dack/ior strobe
// and packs each 16-bit word into a pair of byte lanes

module scsiSequencer (
    input  logic             sclk_i,
    input  logic             reset_i,
    input  logic             enable_i,
    input  logic [15:0]      wordCount_i,
    input  logic             startPulse_i,
    input  logic             dreq_i,
    input  sdmacPkg::pword_t pData_i,
    output logic             dack_o,
    output logic             ior_o,
    output logic             wordTaken_o,
    laneBusIf.feeder         laneBus
);
    import sdmacPkg::*;

    typedef enum logic {
        SQ_IDLE,
        SQ_STROBE
    } sqState_t;

    sqState_t  state;
    logic      upperPair;   // Clear for lanes 0/1, set for lanes 2/3
    laneMask_t target;
    logic      room;
    logic      go;

    assign target = upperPair ? 4'b1100 : 4'b0011;
    assign room   = (laneBus.full & target) == '0;

    // Only answer when a word is still owed and both lanes have space
    assign go = enable_i && (wordCount_i != '0) && dreq_i && room;

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            state     <= SQ_IDLE;
            upperPair <= 1'b0;
        end else begin
            case (state)
                SQ_IDLE: begin
                    if (go)
                        state <= SQ_STROBE;
                end
                default: begin
                    state     <= SQ_IDLE;    // Forces a low cycle between strobes
                    upperPair <= ~upperPair;
                end
            endcase
            if (startPulse_i)
                upperPair <= 1'b0;          // New transfer starts on a longword boundary
        end
    end

    assign dack_o      = state == SQ_STROBE;
    assign ior_o       = state == SQ_STROBE;
    assign wordTaken_o = state == SQ_STROBE;

    // Word is sampled at the end of the strobe cycle
    assign laneBus.push = (state == SQ_STROBE) ? target : '0;

    // Even lanes take the high byte, odd lanes the low byte
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            laneBus.pushData[i] = (i % 2 == 0) ? pData_i[15:8] : pData_i[7:0];
        end
    end

endmodule

//--- rtl/sdmacPkg.sv
// Data types shared across the DMA controller
// Modules take them by a wildcard import in the body,
// port lists use the scoped names

package sdmacPkg;

    // One data byte as held in a lane
    typedef logic [7:0] byte_t;

    // One bit per byte lane, bit i is byte address offset i
    typedef logic [3:0] laneMask_t;

    // Memory longword, lane 0 sits in bits 31:24
    typedef logic [31:0] longword_t;

    // SCSI port word, high byte belongs to the lower address
    typedef logic [15:0] pword_t;

    // Host register index
    typedef logic [1:0] regIdx_t;

    // One byte per lane, indexed by lane number
    typedef byte_t [3:0] laneBytes_t;

endpackage

//--- rtl/sdmacTop.sv
// Top level of the SCSI DMA controller core
// Ties the host registers, SCSI sequencer, byte lanes and bus master
// together; all activity runs on sclk_i

module sdmacTop (
    input  logic                sclk_i,
    input  logic                reset_i,
    input  logic                regWrite_i,
    input  sdmacPkg::regIdx_t   regIdx_i,
    input  logic [31:0]         regWData_i,
    output logic [31:0]         regRData_o,
    input  logic                dreq_i,
    input  sdmacPkg::pword_t    pData_i,
    output logic                dack_o,
    output logic                ior_o,
    input  logic                busGrant_i,
    input  logic                memAck_i,
    output logic                busReq_o,
    output logic                memStrobe_o,
    output sdmacPkg::longword_t memAddr_o,
    output sdmacPkg::longword_t memData_o,
    output sdmacPkg::laneMask_t memByteEn_o,
    output logic                intr_o
);
    import sdmacPkg::*;

    logic        enable;
    logic        startPulse;
    logic        flushReq;
    logic        wordTaken;
    logic        flushDone;
    logic        idle;
    longword_t   startAddr;
    logic [15:0] wordCount;

    laneBusIf laneBus ();

    dmaRegisters uRegisters (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .regWrite_i   (regWrite_i),
        .regIdx_i     (regIdx_i),
        .regWData_i   (regWData_i),
        .regRData_o   (regRData_o),
        .wordTaken_i  (wordTaken),
        .flushDone_i  (flushDone),
        .idle_i       (idle),
        .enable_o     (enable),
        .startPulse_o (startPulse),
        .startAddr_o  (startAddr),
        .wordCount_o  (wordCount),
        .flushReq_o   (flushReq),
        .intr_o       (intr_o)
    );

    scsiSequencer uSequencer (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .enable_i     (enable),
        .wordCount_i  (wordCount),
        .startPulse_i (startPulse),
        .dreq_i       (dreq_i),
        .pData_i      (pData_i),
        .dack_o       (dack_o),
        .ior_o        (ior_o),
        .wordTaken_o  (wordTaken),
        .laneBus      (laneBus)
    );

    // Lane i holds the bytes at address offset i
    for (genvar i = 0; i < 4; i++) begin : genLane
        byteLane uLane (
            .sclk_i     (sclk_i),
            .reset_i    (reset_i),
            .push_i     (laneBus.push[i]),
            .pushData_i (laneBus.pushData[i]),
            .pop_i      (laneBus.pop[i]),
            .popData_o  (laneBus.popData[i]),
            .empty_o    (laneBus.empty[i]),
            .full_o     (laneBus.full[i])
        );
    end

    busMaster uBusMaster (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .startPulse_i (startPulse),
        .startAddr_i  (startAddr),
        .flushReq_i   (flushReq),
        .busGrant_i   (busGrant_i),
        .memAck_i     (memAck_i),
        .busReq_o     (busReq_o),
        .memStrobe_o  (memStrobe_o),
        .memAddr_o    (memAddr_o),
        .memData_o    (memData_o),
        .memByteEn_o  (memByteEn_o),
        .flushDone_o  (flushDone),
        .idle_o       (idle),
        .laneBus      (laneBus)
    );

endmodule

//--- rtl/sdmac_defines.svh
// Constants shared by the DMA controller RTL and its testbench
// Include wherever lane depth or register indices are needed

`ifndef SDMAC_DEFINES_SVH
`define SDMAC_DEFINES_SVH

// Entries per byte lane, keep it a power of two
`define SDMAC_LANE_DEPTH 8

// Host register indices
`define SDMAC_REG_CTRL   2'd0
`define SDMAC_REG_ADDR   2'd1
`define SDMAC_REG_COUNT  2'd2
`define SDMAC_REG_STATUS 2'd3

// Bit positions in the control register
`define SDMAC_CTRL_ENABLE 0
`define SDMAC_CTRL_FLUSH  1
`define SDMAC_CTRL_INTEN  2

`endif

//--- run.sh
#!/bin/sh
# Builds the DMA controller testbench with Verilator and runs it
# A nonzero exit status means the simulation failed
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module sdmacTb -f build.f -o simv

./obj_dir/simv

//--- tests/sdmacSva.sv
// Protocol checker for the DMA controller ports
// Bound into sdmacTop, it watches the SCSI strobes and the memory bus

module sdmacSva (
    input logic                sclk_i,
    input logic                reset_i,
    input logic                dack_i,
    input logic                ior_i,
    input logic                busReq_i,
    input logic                busGrant_i,
    input logic                memStrobe_i,
    input logic                memAck_i,
    input sdmacPkg::longword_t memAddr_i,
    input sdmacPkg::longword_t memData_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic grantSeen;    // Grant observed during the current request

    always_ff @(posedge sclk_i) begin
        if (reset_i)
            grantSeen <= 1'b0;
        else
            grantSeen <= busReq_i && (grantSeen || busGrant_i);
    end

    assert property (@(posedge sclk_i) disable iff (reset_i) ior_i == dack_i)
        else $error("ior and dack differ");

    assert property (@(posedge sclk_i) disable iff (reset_i)
        memStrobe_i |-> busReq_i && grantSeen)
        else $error("memory strobe without request and grant");

    // Address and data hold until the acknowledge
    assert property (@(posedge sclk_i) disable iff (reset_i)
        memStrobe_i && !memAck_i |=> $stable(memAddr_i) && $stable(memData_i))
        else $error("memory address or data changed during a write");

    assert property (@(posedge sclk_i) disable iff (reset_i) dack_i |=> !dack_i)
        else $error("dack held longer than one cycle");

endmodule

bind sdmacTop sdmacSva uSva (
    .sclk_i      (sclk_i),
    .reset_i     (reset_i),
    .dack_i      (dack_o),
    .ior_i       (ior_o),
    .busReq_i    (busReq_o),
    .busGrant_i  (busGrant_i),
    .memStrobe_i (memStrobe_o),
    .memAck_i    (memAck_i),
    .memAddr_i   (memAddr_o),
    .memData_i   (memData_o)
);

//--- tests/sdmacTb.sv
// Random-stimulus testbench for the SCSI DMA controller
// A SCSI port model feeds words, a memory model grants and acknowledges writes
// and checks every longword against the queue of accepted bytes

`include "sdmac_defines.svh"

module sdmacTb;
    timeunit 1ns;
    timeprecision 1ps;
    import sdmacPkg::*;

    localparam int NumRuns       = 6;
    localparam int MaxWords      = 48;
    localparam int TimeoutCycles = NumRuns * MaxWords * 40 + 2000;

    logic        sclk = 1'b0;
    logic        reset;
    logic        regWrite;
    regIdx_t     regIdx;
    logic [31:0] regWData;
    logic [31:0] regRData;
    logic        dreq;
    pword_t      pData;
    logic        dack;
    logic        ior;
    logic        busGrant;
    logic        memAck;
    logic        busReq;
    logic        memStrobe;
    longword_t   memAddr;
    longword_t   memData;
    laneMask_t   memByteEn;
    logic        intr;

    logic [31:0] rngState = 32'hf0b3_27e1;
    byte_t       expQ[$];           // Bytes accepted but not yet written
    int          acceptedWords;
    longword_t   expAddr;
    bit          flushSent;         // Set once the flush command of a run is issued
    int unsigned maxDelay = 4;

    sdmacTop uut (
        .sclk_i (sclk), .reset_i (reset),
        .regWrite_i (regWrite), .regIdx_i (regIdx),
        .regWData_i (regWData), .regRData_o (regRData),
        .dreq_i (dreq), .pData_i (pData), .dack_o (dack), .ior_o (ior),
        .busGrant_i (busGrant), .memAck_i (memAck),
        .busReq_o (busReq), .memStrobe_o (memStrobe),
        .memAddr_o (memAddr), .memData_o (memData),
        .memByteEn_o (memByteEn), .intr_o (intr)
    );

    always #5 sclk = ~sclk;

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkLongword(input string name, input longword_t got, input longword_t exp);
        if (got !== exp)
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkMask(input string name, input laneMask_t got, input laneMask_t exp);
        if (got !== exp)
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkReg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            failRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic writeReg(input regIdx_t idx, input logic [31:0] data);
        @(posedge sclk);
        regWrite <= 1'b1;
        regIdx   <= idx;
        regWData <= data;
        @(posedge sclk);
        regWrite <= 1'b0;
    endtask

    task automatic readReg(input regIdx_t idx, output logic [31:0] data);
        @(posedge sclk);
        regIdx <= idx;
        @(negedge sclk);
        data = regRData;    // Combinational read settles by mid-cycle
    endtask

    // SCSI controller model with random request level and data
    always @(posedge sclk) begin : driveScsiPort
        logic [31:0] r;
        r = nextRand();
        dreq  <= !reset && (r[1:0] != 2'b00);
        pData <= r[31:16];
    end

    always @(negedge sclk) begin
        if (!reset && dack) begin
            expQ.push_back(pData[15:8]);   // High byte is the lower address
            expQ.push_back(pData[7:0]);
            acceptedWords++;
        end
    end

    // Compare one write with the oldest accepted bytes
    task automatic checkWrite();
        int        n;
        laneMask_t expMask;
        longword_t expData;
        n = (expQ.size() >= 4) ? 4 : expQ.size();
        if (n == 0)
            failRun("Memory write started with no accepted bytes outstanding");
        if (n < 4 && !flushSent)
            failRun("Partial memory write issued without a flush command");
        expMask = laneMask_t'((1 << n) - 1);
        expData = '0;
        for (int i = 0; i < n; i++)
            expData[31 - 8 * i -: 8] = expQ.pop_front();
        checkLongword("memAddr_o", memAddr, expAddr);
        checkMask("memByteEn_o", memByteEn, expMask);
        checkLongword("memData_o", memData, expData);
        expAddr += 32'd4;
    endtask

    // Memory side with random grant and acknowledge latency
    initial begin : memoryModel
        int unsigned delay;
        forever begin
            @(negedge sclk);
            if (!reset && busReq) begin
                delay = nextRand() % maxDelay;
                repeat (delay + 1) @(posedge sclk);
                busGrant <= 1'b1;
                do @(negedge sclk); while (!memStrobe);
                checkWrite();
                delay = nextRand() % maxDelay;
                repeat (delay + 1) @(posedge sclk);
                memAck <= 1'b1;
                @(posedge sclk);
                memAck   <= 1'b0;
                busGrant <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TimeoutCycles) @(posedge sclk);
        failRun("Timeout: the transfers did not finish in time");
    end

    task automatic runTransfer(input longword_t addr, input int words, input bit flush,
                               input bit intEn);
        logic [31:0] ctrl;
        logic [31:0] rd;
        ctrl = (32'd1 << `SDMAC_CTRL_ENABLE) | (32'(intEn) << `SDMAC_CTRL_INTEN);
        writeReg(`SDMAC_REG_ADDR, addr);
        writeReg(`SDMAC_REG_COUNT, 32'(words));
        readReg(`SDMAC_REG_ADDR, rd);
        checkReg("start address", rd, addr);
        readReg(`SDMAC_REG_COUNT, rd);
        checkReg("word count", rd, 32'(words));
        expAddr       = addr;
        acceptedWords = 0;
        flushSent     = 1'b0;
        writeReg(`SDMAC_REG_CTRL, ctrl);
        wait (acceptedWords == words);
        if (flush) begin
            flushSent = 1'b1;
            writeReg(`SDMAC_REG_CTRL, ctrl | (32'd1 << `SDMAC_CTRL_FLUSH));
        end
        do readReg(`SDMAC_REG_STATUS, rd); while (!rd[0]);
        checkReg("status", rd, 32'h7);                 // idle, count zero, done
        checkReg("accepted words", 32'(acceptedWords), 32'(words));
        checkReg("unwritten bytes", 32'(expQ.size()), 32'd0);
        checkLongword("final memAddr_o", memAddr, addr + 32'(4 * ((words + 1) / 2)));
        checkReg("intr_o", {31'd0, intr}, {31'd0, intEn});
        writeReg(`SDMAC_REG_CTRL, 32'd0);
        readReg(`SDMAC_REG_STATUS, rd);
        checkReg("status after clear", rd, 32'h6);
        checkReg("intr_o after clear", {31'd0, intr}, 32'd0);
    endtask

    initial begin : mainSequence
        logic [31:0] rd;
        logic [31:0] r;
        int          words;
        bit          flush;
        reset    = 1'b1;
        regWrite = 1'b0;
        regIdx   = '0;
        regWData = '0;
        dreq     = 1'b0;
        pData    = '0;
        busGrant = 1'b0;
        memAck   = 1'b0;
        repeat (4) @(posedge sclk);
        reset <= 1'b0;
        @(negedge sclk);
        checkReg("outputs after reset", {27'd0, dack, ior, busReq, memStrobe, intr}, 32'd0);
        writeReg(`SDMAC_REG_CTRL, 32'd1 << `SDMAC_CTRL_INTEN);
        readReg(`SDMAC_REG_CTRL, rd);
        checkReg("control", rd, 32'h4);
        writeReg(`SDMAC_REG_CTRL, 32'd0);
        for (int run = 0; run < NumRuns; run++) begin
            r        = nextRand();
            flush    = (run % 3) == 2;         // Odd count leaves half a longword
            words    = int'(r[7:0] % (MaxWords / 2)) * 2 + (flush ? 1 : 2);
            // Grant plus acknowledge can outlast filling a whole lane
            maxDelay = (run < 2) ? 4 : `SDMAC_LANE_DEPTH * 4;
            r        = nextRand();
            runTransfer({r[31:2], 2'b00}, words, flush, run[0]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
